// ==== verilog/mem_2r1w_pkg.sv ====
package mem_2r1w_pkg;

  // data word and bank geometry
  localparam int WIDTH   = 16;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;
  localparam int BITADDR = 6;

  // parity bank sits after the data banks
  localparam int XORBNK = NUMVBNK;

  // cycles from bank read strobe to bank read data
  localparam int SRAM_DELAY = 2;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITVBNK-1:0] bank_t;

  // init sweep, then drain, then serving requests
  typedef enum logic [1:0] {
    INIT_CLEAR,
    INIT_DRAIN,
    INIT_READY
  } init_state_t;

endpackage

// ==== verilog/bank_sram.sv ====
`timescale 1ns/1ps

module bank_sram import mem_2r1w_pkg::*; (
  input  logic  clk,
  input  logic  rd,
  input  row_t  rd_row,
  output data_t rd_data,
  input  logic  wr,
  input  row_t  wr_row,
  input  data_t wr_data
);

  data_t mem [NUMVROW];

  // read pipeline, stage 0 holds the array output
  data_t rd_pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_row] <= wr_data;
    end
    // array is sampled before the write of the same edge lands,
    // so a same-row collision returns the old word
    if (rd) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int s = 1; s < SRAM_DELAY; s++) begin
      rd_pipe[s] <= rd_pipe[s-1];
    end
  end

  assign rd_data = rd_pipe[SRAM_DELAY-1];

endmodule

// ==== verilog/init_ctrl.sv ====
`timescale 1ns/1ps

module init_ctrl import mem_2r1w_pkg::*; (
  input  logic clk,
  input  logic rstvld,
  output logic init_busy,
  output row_t init_row,
  output logic ready
);

  init_state_t state;

  // row index during the sweep, drain count afterwards
  row_t cnt;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state <= INIT_CLEAR;
      cnt   <= '0;
      ready <= 1'b0;
    end else begin
      ready <= (state == INIT_READY);
      case (state)
        INIT_CLEAR: begin
          if (cnt == row_t'(NUMVROW-1)) begin
            state <= INIT_DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        INIT_DRAIN: begin
          // let the last clear writes settle through the bank pipes
          if (cnt == row_t'(SRAM_DELAY-1)) begin
            state <= INIT_READY;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= INIT_READY;
        end
      endcase
    end
  end

  assign init_busy = (state == INIT_CLEAR);
  assign init_row  = cnt;

  a_ready_not_busy: assert property (@(posedge clk) disable iff (rstvld)
    !(ready && init_busy))
    else $error("ready is high while the init sweep is still running");

endmodule

// ==== verilog/port_sched.sv ====
`timescale 1ns/1ps

module port_sched import mem_2r1w_pkg::*; (
  input  logic               clk,
  input  logic               rstvld,
  input  logic               ready,
  input  logic               init_busy,
  input  row_t               init_row,
  input  logic               rd0,
  input  addr_t              rd0_addr,
  input  logic               rd1,
  input  addr_t              rd1_addr,
  input  logic               wr,
  input  addr_t              wr_addr,
  input  data_t              wr_data,
  output logic [NUMVBNK:0]   bank_rd,
  output row_t [NUMVBNK:0]   bank_rd_row,
  output logic [NUMVBNK-1:0] bank_wr,
  output row_t               bank_wr_row,
  output data_t              bank_wr_data,
  output logic               rd0_vld_q,
  output bank_t              rd0_bank_q,
  output logic               rd1_vld_q,
  output bank_t              rd1_bank_q,
  output logic               rd1_recon_q,
  output logic               wr_vld_q,
  output bank_t              wr_bank_q,
  output row_t               wr_row_q,
  output data_t              wr_data_q
);

  logic  rd0_acc, rd1_acc, wr_acc, rd1_recon;
  bank_t rd0_bank, rd1_bank, wr_bank;
  row_t  rd0_row, rd1_row, wr_row;

  logic [SRAM_DELAY-1:0] rd0_vld_p, rd1_vld_p, recon_p, wr_vld_p;
  bank_t rd0_bank_p [SRAM_DELAY];
  bank_t rd1_bank_p [SRAM_DELAY];
  bank_t wr_bank_p [SRAM_DELAY];
  row_t  wr_row_p [SRAM_DELAY];
  data_t wr_data_p [SRAM_DELAY];

  // strobes only count once init is done
  assign rd0_acc = rd0 && ready;
  assign rd1_acc = rd1 && ready;
  assign wr_acc  = wr && ready;

  // low bits pick the bank, upper bits the row
  assign rd0_bank = rd0_addr[BITVBNK-1:0];
  assign rd0_row  = rd0_addr[BITADDR-1:BITVBNK];
  assign rd1_bank = rd1_addr[BITVBNK-1:0];
  assign rd1_row  = rd1_addr[BITADDR-1:BITVBNK];
  assign wr_bank  = wr_addr[BITVBNK-1:0];
  assign wr_row   = wr_addr[BITADDR-1:BITVBNK];

  assign rd1_recon = rd0_acc && rd1_acc && (rd0_bank == rd1_bank);

  always_comb begin
    bank_rd     = '0;
    bank_rd_row = '0;
    // old data and old parity for the parity update
    if (wr_acc) begin
      bank_rd[wr_bank]     = 1'b1;
      bank_rd_row[wr_bank] = wr_row;
      bank_rd[XORBNK]      = 1'b1;
      bank_rd_row[XORBNK]  = wr_row;
    end
    if (rd0_acc) begin
      bank_rd[rd0_bank]     = 1'b1;
      bank_rd_row[rd0_bank] = rd0_row;
    end
    if (rd1_acc) begin
      if (rd1_recon) begin
        // every bank but the busy one, parity bank included
        for (int b = 0; b <= NUMVBNK; b++) begin
          if (b != rd1_bank) begin
            bank_rd[b]     = 1'b1;
            bank_rd_row[b] = rd1_row;
          end
        end
      end else begin
        bank_rd[rd1_bank]     = 1'b1;
        bank_rd_row[rd1_bank] = rd1_row;
      end
    end
  end

  always_comb begin
    if (init_busy) begin
      bank_wr      = '1;
      bank_wr_row  = init_row;
      bank_wr_data = '0;
    end else begin
      bank_wr          = '0;
      bank_wr[wr_bank] = wr_acc;
      bank_wr_row      = wr_row;
      bank_wr_data     = wr_data;
    end
  end

  // request facts travel alongside the bank reads
  always_ff @(posedge clk) begin
    if (rstvld) begin
      rd0_vld_p <= '0;
      rd1_vld_p <= '0;
      recon_p   <= '0;
      wr_vld_p  <= '0;
    end else begin
      rd0_vld_p <= {rd0_vld_p[SRAM_DELAY-2:0], rd0_acc};
      rd1_vld_p <= {rd1_vld_p[SRAM_DELAY-2:0], rd1_acc};
      recon_p   <= {recon_p[SRAM_DELAY-2:0], rd1_recon};
      wr_vld_p  <= {wr_vld_p[SRAM_DELAY-2:0], wr_acc};
    end
  end

  always_ff @(posedge clk) begin
    rd0_bank_p[0] <= rd0_bank;
    rd1_bank_p[0] <= rd1_bank;
    wr_bank_p[0]  <= wr_bank;
    wr_row_p[0]   <= wr_row;
    wr_data_p[0]  <= wr_data;
    for (int s = 1; s < SRAM_DELAY; s++) begin
      rd0_bank_p[s] <= rd0_bank_p[s-1];
      rd1_bank_p[s] <= rd1_bank_p[s-1];
      wr_bank_p[s]  <= wr_bank_p[s-1];
      wr_row_p[s]   <= wr_row_p[s-1];
      wr_data_p[s]  <= wr_data_p[s-1];
    end
  end

  assign rd0_vld_q   = rd0_vld_p[SRAM_DELAY-1];
  assign rd0_bank_q  = rd0_bank_p[SRAM_DELAY-1];
  assign rd1_vld_q   = rd1_vld_p[SRAM_DELAY-1];
  assign rd1_bank_q  = rd1_bank_p[SRAM_DELAY-1];
  assign rd1_recon_q = recon_p[SRAM_DELAY-1];
  assign wr_vld_q    = wr_vld_p[SRAM_DELAY-1];
  assign wr_bank_q   = wr_bank_p[SRAM_DELAY-1];
  assign wr_row_q    = wr_row_p[SRAM_DELAY-1];
  assign wr_data_q   = wr_data_p[SRAM_DELAY-1];

  a_no_rw_collision: assert property (@(posedge clk) disable iff (rstvld)
    wr_acc |-> !(rd0 || rd1))
    else $error("write accepted in the same cycle as a read strobe");

endmodule

// ==== verilog/xor_fwd.sv ====
`timescale 1ns/1ps

module xor_fwd import mem_2r1w_pkg::*; (
  input  logic  clk,
  input  logic  rstvld,
  input  logic  xor_rd,
  input  row_t  xor_rd_row,
  input  data_t xor_dout,
  input  logic  xor_wr,
  input  row_t  xor_wr_row,
  input  data_t xor_wr_data,
  output data_t xor_data
);

  // tracked read per stage, the last stage needs no row
  logic trk_rd [SRAM_DELAY-1];
  row_t trk_row [SRAM_DELAY-1];

  logic [SRAM_DELAY-1:0] hit;
  logic [SRAM_DELAY-1:0] fwd_vld;
  data_t fwd_data [SRAM_DELAY];

  always_comb begin
    // stage 0 catches a write in the read's own cycle,
    // the bank hands back the old word in that case
    hit[0] = xor_rd && xor_wr && (xor_wr_row == xor_rd_row);
    for (int s = 1; s < SRAM_DELAY; s++) begin
      hit[s] = trk_rd[s-1] && xor_wr && (xor_wr_row == trk_row[s-1]);
    end
  end

  always_ff @(posedge clk) begin
    if (rstvld) begin
      for (int s = 0; s < SRAM_DELAY-1; s++) begin
        trk_rd[s] <= 1'b0;
      end
      fwd_vld <= '0;
    end else begin
      trk_rd[0] <= xor_rd;
      for (int s = 1; s < SRAM_DELAY-1; s++) begin
        trk_rd[s] <= trk_rd[s-1];
      end
      fwd_vld[0] <= hit[0];
      for (int s = 1; s < SRAM_DELAY; s++) begin
        fwd_vld[s] <= hit[s] || fwd_vld[s-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    trk_row[0]  <= xor_rd_row;
    fwd_data[0] <= xor_wr_data;
    for (int s = 1; s < SRAM_DELAY-1; s++) begin
      trk_row[s] <= trk_row[s-1];
    end
    // newer write wins over an earlier capture
    for (int s = 1; s < SRAM_DELAY; s++) begin
      fwd_data[s] <= hit[s] ? xor_wr_data : fwd_data[s-1];
    end
  end

  assign xor_data = fwd_vld[SRAM_DELAY-1] ? fwd_data[SRAM_DELAY-1] : xor_dout;

endmodule

// ==== verilog/recover_xor.sv ====
`timescale 1ns/1ps

module recover_xor import mem_2r1w_pkg::*; (
  input  logic                clk,
  input  logic                rstvld,
  input  logic                rd0_vld_q,
  input  bank_t               rd0_bank_q,
  input  logic                rd1_vld_q,
  input  bank_t               rd1_bank_q,
  input  logic                rd1_recon_q,
  input  logic                wr_vld_q,
  input  bank_t               wr_bank_q,
  input  row_t                wr_row_q,
  input  data_t               wr_data_q,
  input  data_t [NUMVBNK-1:0] bank_dout,
  input  data_t               xor_data,
  input  logic                init_busy,
  input  row_t                init_row,
  output logic                rd0_vld,
  output data_t               rd0_data,
  output logic                rd1_vld,
  output data_t               rd1_data,
  output logic                xor_wr,
  output row_t                xor_wr_row,
  output data_t               xor_wr_data
);

  data_t recon_data;

  // rebuild the busy bank's word from the row parity
  always_comb begin
    recon_data = xor_data;
    for (int b = 0; b < NUMVBNK; b++) begin
      if (b != rd1_bank_q) begin
        recon_data = recon_data ^ bank_dout[b];
      end
    end
  end

  assign rd0_vld  = rd0_vld_q;
  assign rd0_data = bank_dout[rd0_bank_q];
  assign rd1_vld  = rd1_vld_q;
  assign rd1_data = rd1_recon_q ? recon_data : bank_dout[rd1_bank_q];

  always_comb begin
    if (init_busy) begin
      xor_wr      = 1'b1;
      xor_wr_row  = init_row;
      xor_wr_data = '0;
    end else begin
      // old data out, new data in
      xor_wr      = wr_vld_q;
      xor_wr_row  = wr_row_q;
      xor_wr_data = bank_dout[wr_bank_q] ^ xor_data ^ wr_data_q;
    end
  end

  a_recon_no_update: assert property (@(posedge clk) disable iff (rstvld)
    !(wr_vld_q && rd1_recon_q))
    else $error("parity update and read reconstruction share the parity bank");

endmodule

// ==== verilog/mem_2r1w_top.sv ====
`timescale 1ns/1ps

module mem_2r1w_top import mem_2r1w_pkg::*; (
  input  logic  clk,
  input  logic  rstvld,
  input  logic  rd0,
  input  addr_t rd0_addr,
  input  logic  rd1,
  input  addr_t rd1_addr,
  input  logic  wr,
  input  addr_t wr_addr,
  input  data_t wr_data,
  output logic  rd0_vld,
  output data_t rd0_data,
  output logic  rd1_vld,
  output data_t rd1_data,
  output logic  ready
);

  logic init_busy;
  row_t init_row;

  // bank side
  logic [NUMVBNK:0]   bank_rd;
  row_t [NUMVBNK:0]   bank_rd_row;
  logic [NUMVBNK-1:0] bank_wr;
  row_t               bank_wr_row;
  data_t              bank_wr_data;
  data_t [NUMVBNK-1:0] bank_dout;
  data_t              xor_dout;
  data_t              xor_data;
  logic               xor_wr;
  row_t               xor_wr_row;
  data_t              xor_wr_data;

  // request facts at bank data time
  logic  rd0_vld_q, rd1_vld_q, rd1_recon_q, wr_vld_q;
  bank_t rd0_bank_q, rd1_bank_q, wr_bank_q;
  row_t  wr_row_q;
  data_t wr_data_q;

  init_ctrl i_init_ctrl (
    .clk, .rstvld, .init_busy, .init_row, .ready
  );

  port_sched i_port_sched (
    .clk, .rstvld, .ready, .init_busy, .init_row,
    .rd0, .rd0_addr, .rd1, .rd1_addr, .wr, .wr_addr, .wr_data,
    .bank_rd, .bank_rd_row, .bank_wr, .bank_wr_row, .bank_wr_data,
    .rd0_vld_q, .rd0_bank_q, .rd1_vld_q, .rd1_bank_q, .rd1_recon_q,
    .wr_vld_q, .wr_bank_q, .wr_row_q, .wr_data_q
  );

  xor_fwd i_xor_fwd (
    .clk, .rstvld,
    .xor_rd     (bank_rd[XORBNK]),
    .xor_rd_row (bank_rd_row[XORBNK]),
    .xor_dout, .xor_wr, .xor_wr_row, .xor_wr_data, .xor_data
  );

  recover_xor i_recover_xor (
    .clk, .rstvld,
    .rd0_vld_q, .rd0_bank_q, .rd1_vld_q, .rd1_bank_q, .rd1_recon_q,
    .wr_vld_q, .wr_bank_q, .wr_row_q, .wr_data_q,
    .bank_dout, .xor_data, .init_busy, .init_row,
    .rd0_vld, .rd0_data, .rd1_vld, .rd1_data,
    .xor_wr, .xor_wr_row, .xor_wr_data
  );

  for (genvar b = 0; b <= NUMVBNK; b++) begin : g_bank
    if (b == XORBNK) begin : g_xor
      // parity bank, written by the update path
      bank_sram i_bank (
        .clk, .rd(bank_rd[b]), .rd_row(bank_rd_row[b]), .rd_data(xor_dout),
        .wr(xor_wr), .wr_row(xor_wr_row), .wr_data(xor_wr_data)
      );
    end else begin : g_data
      bank_sram i_bank (
        .clk, .rd(bank_rd[b]), .rd_row(bank_rd_row[b]), .rd_data(bank_dout[b]),
        .wr(bank_wr[b]), .wr_row(bank_wr_row), .wr_data(bank_wr_data)
      );
    end
  end

endmodule

// ==== dv/tb_mem_2r1w.sv ====
`timescale 1ns/1ps

module tb_mem_2r1w import mem_2r1w_pkg::*; ();

  localparam int RESET_CYCLES = 5;
  localparam int READY_CYCLES = NUMVROW + SRAM_DELAY + 1;
  localparam int NUM_ADDR     = NUMVBNK * NUMVROW;
  localparam int NUM_RANDOM   = 300;
  // about 500 cycles of reset, init, directed and random operations, doubled
  localparam int MAX_CYCLES   = 1000;

  logic  clk = 1'b0;
  logic  rstvld;
  logic  rd0, rd1, wr;
  addr_t rd0_addr, rd1_addr, wr_addr;
  data_t wr_data;
  logic  rd0_vld, rd1_vld, ready;
  data_t rd0_data, rd1_data;

  integer seed = 25804;
  int     ready_errors = 0;
  int     vld_errors = 0;
  int     data_errors = 0;
  int     cycle_cnt = 0;
  int     rst_cyc = 0;

  // reference copy of the stored words
  data_t ref_mem [NUM_ADDR];

  // expected results, two stages to match the bank latency
  logic  exp0_vld_q1, exp0_vld_q2, exp1_vld_q1, exp1_vld_q2;
  data_t exp0_data_q1, exp0_data_q2, exp1_data_q1, exp1_data_q2;

  mem_2r1w_top i_dut (
    .clk, .rstvld,
    .rd0, .rd0_addr, .rd1, .rd1_addr,
    .wr, .wr_addr, .wr_data,
    .rd0_vld, .rd0_data, .rd1_vld, .rd1_data,
    .ready
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    if (rstvld) begin
      // init sweep leaves every word at zero
      for (int i = 0; i < NUM_ADDR; i++) begin
        ref_mem[i] <= '0;
      end
      rst_cyc     <= 0;
      exp0_vld_q1 <= 1'b0;
      exp0_vld_q2 <= 1'b0;
      exp1_vld_q1 <= 1'b0;
      exp1_vld_q2 <= 1'b0;
    end else begin
      if (rst_cyc < READY_CYCLES) begin
        rst_cyc <= rst_cyc + 1;
      end
      if (wr && ready) begin
        ref_mem[wr_addr] <= wr_data;
      end
      exp0_vld_q1  <= rd0 && ready;
      exp0_data_q1 <= ref_mem[rd0_addr];
      exp1_vld_q1  <= rd1 && ready;
      exp1_data_q1 <= ref_mem[rd1_addr];
      exp0_vld_q2  <= exp0_vld_q1;
      exp0_data_q2 <= exp0_data_q1;
      exp1_vld_q2  <= exp1_vld_q1;
      exp1_data_q2 <= exp1_data_q1;
    end
  end

  a_ready_timing: assert property (@(posedge clk) disable iff (rstvld)
    ready == (rst_cyc >= READY_CYCLES))
    else begin
      ready_errors++;
      $display("[ERROR] %0t ready expected %b actual %b", $time,
               $sampled(rst_cyc) >= READY_CYCLES, $sampled(ready));
    end

  a_rd0_vld: assert property (@(posedge clk) disable iff (rstvld)
    rd0_vld == exp0_vld_q2)
    else begin
      vld_errors++;
      $display("[ERROR] %0t rd0_vld expected %b actual %b", $time,
               $sampled(exp0_vld_q2), $sampled(rd0_vld));
    end

  a_rd1_vld: assert property (@(posedge clk) disable iff (rstvld)
    rd1_vld == exp1_vld_q2)
    else begin
      vld_errors++;
      $display("[ERROR] %0t rd1_vld expected %b actual %b", $time,
               $sampled(exp1_vld_q2), $sampled(rd1_vld));
    end

  a_rd0_data: assert property (@(posedge clk) disable iff (rstvld)
    exp0_vld_q2 |-> (rd0_data == exp0_data_q2))
    else begin
      data_errors++;
      $display("[ERROR] %0t rd0_data expected %h actual %h", $time,
               $sampled(exp0_data_q2), $sampled(rd0_data));
    end

  a_rd1_data: assert property (@(posedge clk) disable iff (rstvld)
    exp1_vld_q2 |-> (rd1_data == exp1_data_q2))
    else begin
      data_errors++;
      $display("[ERROR] %0t rd1_data expected %h actual %h", $time,
               $sampled(exp1_data_q2), $sampled(rd1_data));
    end

  function automatic addr_t make_addr(row_t r, bank_t b);
    return {r, b};
  endfunction

  // word pattern built from the whole address and a tag
  function automatic data_t addr_pattern(addr_t a, logic [3:0] tag);
    return {tag, a, ~a};
  endfunction

  task automatic drive(logic r0, addr_t a0, logic r1, addr_t a1,
                       logic w, addr_t wa, data_t wd);
    rd0      = r0;
    rd0_addr = a0;
    rd1      = r1;
    rd1_addr = a1;
    wr       = w;
    wr_addr  = wa;
    wr_data  = wd;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_op(addr_t a, data_t d);
    next_cycle();
    drive(1'b0, '0, 1'b0, '0, 1'b1, a, d);
  endtask

  task automatic read_op(logic e0, addr_t a0, logic e1, addr_t a1);
    next_cycle();
    drive(e0, a0, e1, a1, 1'b0, '0, '0);
  endtask

  task automatic idle_op();
    next_cycle();
    drive(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
  endtask

  // strobes during the init sweep must be ignored
  task automatic strobe_while_busy();
    int n;
    n = 0;
    while (!ready) begin
      if (n % 2 == 0) begin
        drive(1'b0, '0, 1'b0, '0, 1'b1, addr_t'(n), addr_pattern(addr_t'(n), 4'hF));
      end else begin
        drive(1'b1, addr_t'(n), 1'b1, addr_t'(n + 1), 1'b0, '0, '0);
      end
      n++;
      next_cycle();
    end
    drive(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic zero_sweep();
    for (int a = 0; a < NUM_ADDR; a += 2) begin
      read_op(1'b1, addr_t'(a), 1'b1, addr_t'(a + 1));
    end
  endtask

  task automatic write_then_read();
    addr_t a;
    for (int i = 0; i < 8; i++) begin
      a = addr_t'(i * 13 + 5);
      write_op(a, addr_pattern(a, 4'h1));
      read_op(1'b1, a, 1'b1, a ^ addr_t'(1));
      read_op(1'b1, a ^ addr_t'(2), 1'b1, a);
    end
  endtask

  task automatic fill_all();
    for (int a = 0; a < NUM_ADDR; a++) begin
      write_op(addr_t'(a), addr_pattern(addr_t'(a), 4'h2));
    end
  endtask

  // same bank, different rows, so port 1 rebuilds from parity
  task automatic same_bank_pairs();
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int r = 0; r < NUMVROW / 2; r++) begin
        read_op(1'b1, make_addr(row_t'(r), bank_t'(b)),
                1'b1, make_addr(row_t'(NUMVROW - 1 - r), bank_t'(b)));
      end
    end
  endtask

  // parity updates still in flight when the rebuild reads the parity row
  task automatic forward_cases();
    row_t r;
    for (int i = 0; i < 2; i++) begin
      r = (i == 0) ? row_t'(3) : row_t'(12);
      write_op(make_addr(r, 1), addr_pattern(make_addr(r, 1), 4'h3));
      write_op(make_addr(r, 1), addr_pattern(make_addr(r, 1), 4'h4));
      read_op(1'b1, make_addr(r ^ row_t'(8), 1), 1'b1, make_addr(r, 1));
      read_op(1'b1, make_addr(r, 1), 1'b1, make_addr(r ^ row_t'(8), 1));
      write_op(make_addr(r, 1), addr_pattern(make_addr(r, 1), 4'h5));
      write_op(make_addr(r, 2), addr_pattern(make_addr(r, 2), 4'h6));
      read_op(1'b1, make_addr(r ^ row_t'(4), 0), 1'b1, make_addr(r, 0));
    end
  endtask

  task automatic random_ops();
    int    kind;
    addr_t a0;
    addr_t a1;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      kind = $unsigned($random(seed)) % 10;
      a0   = addr_t'($random(seed));
      a1   = addr_t'($random(seed));
      if (kind < 4) begin
        write_op(a0, data_t'($random(seed)));
      end else if (kind < 9) begin
        // half of the pairs land in one bank
        if ($random(seed) & 1) begin
          a1 = make_addr(a1[BITADDR-1:BITVBNK], a0[BITVBNK-1:0]);
        end
        read_op(1'($random(seed)), a0, 1'($random(seed)), a1);
      end else begin
        idle_op();
      end
    end
  endtask

  initial begin
    rstvld = 1'b1;
    drive(1'b0, '0, 1'b0, '0, 1'b0, '0, '0);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstvld = 1'b0;

    strobe_while_busy();
    zero_sweep();
    write_then_read();
    fill_all();
    same_bank_pairs();
    forward_cases();
    random_ops();
    repeat (SRAM_DELAY + 2) idle_op();

    $display("error counts: ready %0d, rd_vld %0d, rd_data %0d",
             ready_errors, vld_errors, data_errors);
    if (ready_errors + vld_errors + data_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout after %0d cycles, the test sequence did not complete", MAX_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/mem_2r1w_pkg.sv
verilog/bank_sram.sv
verilog/init_ctrl.sv
verilog/port_sched.sv
verilog/xor_fwd.sv
verilog/recover_xor.sv
verilog/mem_2r1w_top.sv
dv/tb_mem_2r1w.sv
